// ==== hdl/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // datapath widths
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned shamt_w    = 5;

    // sequential pc step
    localparam int unsigned inst_bytes = 4;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        // second operand straight through
        alu_lui  = 4'd11
    } alu_op_t;

    // branch kinds, codes 0 to 2 unused
    typedef enum logic [3:0] {
        br_jirl = 4'd3,
        br_b    = 4'd4,
        br_bl   = 4'd5,
        br_beq  = 4'd6,
        br_bne  = 4'd7,
        br_blt  = 4'd8,
        br_bge  = 4'd9,
        br_bltu = 4'd10,
        br_bgeu = 4'd11
    } br_op_t;

endpackage

`default_nettype wire

// ==== hdl/exe_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_forward (
    input  wire exe_pkg::reg_addr_t lane0_rj,
    input  wire exe_pkg::reg_addr_t lane0_rk,
    input  wire exe_pkg::reg_addr_t lane1_rj,
    input  wire exe_pkg::reg_addr_t lane1_rk,
    input  wire exe_pkg::word_t     rf_data00,
    input  wire exe_pkg::word_t     rf_data01,
    input  wire exe_pkg::word_t     rf_data10,
    input  wire exe_pkg::word_t     rf_data11,
    input  wire logic               lane0_src2_imm,
    input  wire logic               lane1_src2_imm,
    input  wire exe_pkg::word_t     lane0_imm,
    input  wire exe_pkg::word_t     lane1_imm,
    input  wire logic               mid_en0,
    input  wire logic               mid_en1,
    input  wire exe_pkg::reg_addr_t mid_rd0,
    input  wire exe_pkg::reg_addr_t mid_rd1,
    input  wire exe_pkg::word_t     mid_data0,
    input  wire exe_pkg::word_t     mid_data1,
    input  wire logic               fin_en0,
    input  wire logic               fin_en1,
    input  wire exe_pkg::reg_addr_t fin_rd0,
    input  wire exe_pkg::reg_addr_t fin_rd1,
    input  wire exe_pkg::word_t     fin_data0,
    input  wire exe_pkg::word_t     fin_data1,
    output exe_pkg::word_t          lane0_sr0,
    output exe_pkg::word_t          lane0_sr1,
    output exe_pkg::word_t          lane0_alu_sr1,
    output exe_pkg::word_t          lane1_sr0,
    output exe_pkg::word_t          lane1_alu_sr1
);

    exe_pkg::word_t lane1_sr1;

    // newest in-flight producer wins, younger lane first within a stage
    function automatic exe_pkg::word_t pick(input exe_pkg::reg_addr_t idx,
                                            input exe_pkg::word_t rf);
        if (idx == '0)
            return '0;
        else if (mid_en1 && mid_rd1 == idx)
            return mid_data1;
        else if (mid_en0 && mid_rd0 == idx)
            return mid_data0;
        else if (fin_en1 && fin_rd1 == idx)
            return fin_data1;
        else if (fin_en0 && fin_rd0 == idx)
            return fin_data0;
        else
            return rf;
    endfunction

    assign lane0_sr0 = pick(lane0_rj, rf_data00);
    assign lane0_sr1 = pick(lane0_rk, rf_data01);
    assign lane1_sr0 = pick(lane1_rj, rf_data10);
    assign lane1_sr1 = pick(lane1_rk, rf_data11);

    // branch compare keeps the register value in lane0_sr1
    assign lane0_alu_sr1 = lane0_src2_imm ? lane0_imm : lane0_sr1;
    assign lane1_alu_sr1 = lane1_src2_imm ? lane1_imm : lane1_sr1;

endmodule

`default_nettype wire

// ==== hdl/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
    input  wire exe_pkg::alu_op_t alu_op,
    input  wire exe_pkg::word_t   sr0,
    input  wire exe_pkg::word_t   sr1,
    output exe_pkg::word_t        result
);

    logic [exe_pkg::shamt_w-1:0] shamt;
    logic                        lt_signed;
    logic                        lt_unsigned;

    assign shamt       = sr1[exe_pkg::shamt_w-1:0];
    assign lt_signed   = $signed(sr0) < $signed(sr1);
    assign lt_unsigned = sr0 < sr1;

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add: begin
                result = sr0 + sr1;
            end
            exe_pkg::alu_sub: begin
                result = sr0 - sr1;
            end
            exe_pkg::alu_slt: begin
                result = {{(exe_pkg::xlen-1){1'b0}}, lt_signed};
            end
            exe_pkg::alu_sltu: begin
                result = {{(exe_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            exe_pkg::alu_and: begin
                result = sr0 & sr1;
            end
            exe_pkg::alu_or: begin
                result = sr0 | sr1;
            end
            exe_pkg::alu_xor: begin
                result = sr0 ^ sr1;
            end
            exe_pkg::alu_nor: begin
                result = ~(sr0 | sr1);
            end
            exe_pkg::alu_sll: begin
                result = sr0 << shamt;
            end
            exe_pkg::alu_srl: begin
                result = sr0 >> shamt;
            end
            exe_pkg::alu_sra: begin
                result = $signed(sr0) >>> shamt;
            end
            exe_pkg::alu_lui: begin
                result = sr1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exe_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_branch (
    input  wire exe_pkg::br_op_t br_op,
    input  wire exe_pkg::word_t  pc,
    input  wire exe_pkg::word_t  pc_next,
    input  wire exe_pkg::word_t  sr0,
    input  wire exe_pkg::word_t  sr1,
    input  wire exe_pkg::word_t  imm,
    output exe_pkg::word_t       link_data,
    output logic                 writes_link,
    output logic                 mispredict,
    output exe_pkg::word_t       target
);

    logic           taken;
    logic           eq;
    logic           lt_s;
    logic           lt_u;
    exe_pkg::word_t seq_pc;

    assign eq     = sr0 == sr1;
    assign lt_s   = $signed(sr0) < $signed(sr1);
    assign lt_u   = sr0 < sr1;
    assign seq_pc = pc + exe_pkg::inst_bytes;

    always_comb begin
        case (br_op)
            exe_pkg::br_jirl,
            exe_pkg::br_b,
            exe_pkg::br_bl: begin
                taken = 1'b1;
            end
            exe_pkg::br_beq: begin
                taken = eq;
            end
            exe_pkg::br_bne: begin
                taken = !eq;
            end
            exe_pkg::br_blt: begin
                taken = lt_s;
            end
            exe_pkg::br_bge: begin
                taken = !lt_s;
            end
            exe_pkg::br_bltu: begin
                taken = lt_u;
            end
            exe_pkg::br_bgeu: begin
                taken = !lt_u;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // resolved next pc
    always_comb begin
        if (br_op == exe_pkg::br_jirl)
            target = sr0 + imm;
        else if (taken)
            target = pc + imm;
        else
            target = seq_pc;
    end

    assign mispredict  = target != pc_next;
    assign writes_link = (br_op == exe_pkg::br_bl) || (br_op == exe_pkg::br_jirl);
    assign link_data   = seq_pc;

endmodule

`default_nettype wire

// ==== hdl/exe_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_pipe (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wb_flush,
    input  wire logic               lane0_en,
    input  wire logic               lane0_is_branch,
    input  wire logic               lane1_en,
    input  wire exe_pkg::reg_addr_t lane0_rd,
    input  wire exe_pkg::reg_addr_t lane1_rd,
    input  wire exe_pkg::word_t     lane0_pc,
    input  wire exe_pkg::word_t     lane1_pc,
    input  wire exe_pkg::word_t     alu_result0,
    input  wire exe_pkg::word_t     alu_result1,
    input  wire exe_pkg::word_t     link_data,
    input  wire exe_pkg::word_t     br_target,
    input  wire logic               writes_link,
    input  wire logic               mispredict,
    output logic                    mid_en0,
    output logic                    mid_en1,
    output exe_pkg::reg_addr_t      mid_rd0,
    output exe_pkg::reg_addr_t      mid_rd1,
    output exe_pkg::word_t          mid_data0,
    output exe_pkg::word_t          mid_data1,
    output logic                    en_out0,
    output logic                    en_out1,
    output exe_pkg::reg_addr_t      addr_out0,
    output exe_pkg::reg_addr_t      addr_out1,
    output exe_pkg::word_t          data_out0,
    output exe_pkg::word_t          data_out1,
    output exe_pkg::word_t          pc_out0,
    output exe_pkg::word_t          pc_out1,
    output logic                    flush,
    output exe_pkg::word_t          redirect_pc,
    output exe_pkg::word_t          branch_pc
);

    logic           lane0_wr;
    logic           lane1_wr;
    logic           br_flush;
    exe_pkg::word_t mid_pc0;
    exe_pkg::word_t mid_pc1;

    // r0 never written, branches write only a link
    assign lane0_wr = lane0_en && (lane0_rd != '0) && (!lane0_is_branch || writes_link);
    assign lane1_wr = lane1_en && (lane1_rd != '0);
    assign br_flush = lane0_en && lane0_is_branch && mispredict;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_en0 <= 1'b0;
            mid_en1 <= 1'b0;
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
            flush   <= 1'b0;
        end else if (wb_flush) begin
            mid_en0 <= 1'b0;
            mid_en1 <= 1'b0;
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
            flush   <= 1'b0;
        end else begin
            // bundle arriving during a flush is dropped
            mid_en0 <= lane0_wr && !flush;
            mid_en1 <= lane1_wr && !flush;
            flush   <= br_flush && !flush;
            en_out0 <= mid_en0;
            // lane 1 sits behind the mispredicted branch
            en_out1 <= mid_en1 && !flush;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd0     <= lane0_rd;
        mid_rd1     <= lane1_rd;
        mid_data0   <= lane0_is_branch ? link_data : alu_result0;
        mid_data1   <= alu_result1;
        mid_pc0     <= lane0_pc;
        mid_pc1     <= lane1_pc;
        redirect_pc <= br_target;
    end

    always_ff @(posedge clk) begin
        addr_out0 <= mid_rd0;
        addr_out1 <= mid_rd1;
        data_out0 <= mid_data0;
        data_out1 <= mid_data1;
        pc_out0   <= mid_pc0;
        pc_out1   <= mid_pc1;
    end

    // middle stage still holds the branch while flush is up
    assign branch_pc = mid_pc0;

endmodule

`default_nettype wire

// ==== hdl/exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wb_flush,
    input  wire logic               lane0_en,
    input  wire logic               lane0_is_branch,
    input  wire exe_pkg::alu_op_t   lane0_alu_op,
    input  wire exe_pkg::br_op_t    lane0_br_op,
    input  wire logic               lane0_src2_imm,
    input  wire exe_pkg::reg_addr_t lane0_rd,
    input  wire exe_pkg::reg_addr_t lane0_rj,
    input  wire exe_pkg::reg_addr_t lane0_rk,
    input  wire exe_pkg::word_t     lane0_imm,
    input  wire exe_pkg::word_t     lane0_pc,
    input  wire exe_pkg::word_t     lane0_pc_next,
    input  wire exe_pkg::word_t     rf_data00,
    input  wire exe_pkg::word_t     rf_data01,
    input  wire logic               lane1_en,
    input  wire exe_pkg::alu_op_t   lane1_alu_op,
    input  wire logic               lane1_src2_imm,
    input  wire exe_pkg::reg_addr_t lane1_rd,
    input  wire exe_pkg::reg_addr_t lane1_rj,
    input  wire exe_pkg::reg_addr_t lane1_rk,
    input  wire exe_pkg::word_t     lane1_imm,
    input  wire exe_pkg::word_t     lane1_pc,
    input  wire exe_pkg::word_t     rf_data10,
    input  wire exe_pkg::word_t     rf_data11,
    output logic                    en_out0,
    output exe_pkg::reg_addr_t      addr_out0,
    output exe_pkg::word_t          data_out0,
    output exe_pkg::word_t          pc_out0,
    output logic                    en_out1,
    output exe_pkg::reg_addr_t      addr_out1,
    output exe_pkg::word_t          data_out1,
    output exe_pkg::word_t          pc_out1,
    output logic                    flush,
    output exe_pkg::word_t          redirect_pc,
    output exe_pkg::word_t          branch_pc
);

    exe_pkg::word_t     lane0_sr0;
    exe_pkg::word_t     lane0_sr1;
    exe_pkg::word_t     lane0_alu_sr1;
    exe_pkg::word_t     lane1_sr0;
    exe_pkg::word_t     lane1_alu_sr1;
    exe_pkg::word_t     alu_result0;
    exe_pkg::word_t     alu_result1;
    exe_pkg::word_t     link_data;
    exe_pkg::word_t     br_target;
    logic               writes_link;
    logic               mispredict;
    logic               mid_en0;
    logic               mid_en1;
    exe_pkg::reg_addr_t mid_rd0;
    exe_pkg::reg_addr_t mid_rd1;
    exe_pkg::word_t     mid_data0;
    exe_pkg::word_t     mid_data1;

    // final stage forwards straight from the output registers
    exe_forward u_forward (
        .lane0_rj       (lane0_rj),
        .lane0_rk       (lane0_rk),
        .lane1_rj       (lane1_rj),
        .lane1_rk       (lane1_rk),
        .rf_data00      (rf_data00),
        .rf_data01      (rf_data01),
        .rf_data10      (rf_data10),
        .rf_data11      (rf_data11),
        .lane0_src2_imm (lane0_src2_imm),
        .lane1_src2_imm (lane1_src2_imm),
        .lane0_imm      (lane0_imm),
        .lane1_imm      (lane1_imm),
        .mid_en0        (mid_en0),
        .mid_en1        (mid_en1),
        .mid_rd0        (mid_rd0),
        .mid_rd1        (mid_rd1),
        .mid_data0      (mid_data0),
        .mid_data1      (mid_data1),
        .fin_en0        (en_out0),
        .fin_en1        (en_out1),
        .fin_rd0        (addr_out0),
        .fin_rd1        (addr_out1),
        .fin_data0      (data_out0),
        .fin_data1      (data_out1),
        .lane0_sr0      (lane0_sr0),
        .lane0_sr1      (lane0_sr1),
        .lane0_alu_sr1  (lane0_alu_sr1),
        .lane1_sr0      (lane1_sr0),
        .lane1_alu_sr1  (lane1_alu_sr1)
    );

    exe_alu u_alu0 (
        .alu_op (lane0_alu_op),
        .sr0    (lane0_sr0),
        .sr1    (lane0_alu_sr1),
        .result (alu_result0)
    );

    exe_alu u_alu1 (
        .alu_op (lane1_alu_op),
        .sr0    (lane1_sr0),
        .sr1    (lane1_alu_sr1),
        .result (alu_result1)
    );

    exe_branch u_branch (
        .br_op       (lane0_br_op),
        .pc          (lane0_pc),
        .pc_next     (lane0_pc_next),
        .sr0         (lane0_sr0),
        .sr1         (lane0_sr1),
        .imm         (lane0_imm),
        .link_data   (link_data),
        .writes_link (writes_link),
        .mispredict  (mispredict),
        .target      (br_target)
    );

    exe_pipe u_pipe (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_flush        (wb_flush),
        .lane0_en        (lane0_en),
        .lane0_is_branch (lane0_is_branch),
        .lane1_en        (lane1_en),
        .lane0_rd        (lane0_rd),
        .lane1_rd        (lane1_rd),
        .lane0_pc        (lane0_pc),
        .lane1_pc        (lane1_pc),
        .alu_result0     (alu_result0),
        .alu_result1     (alu_result1),
        .link_data       (link_data),
        .br_target       (br_target),
        .writes_link     (writes_link),
        .mispredict      (mispredict),
        .mid_en0         (mid_en0),
        .mid_en1         (mid_en1),
        .mid_rd0         (mid_rd0),
        .mid_rd1         (mid_rd1),
        .mid_data0       (mid_data0),
        .mid_data1       (mid_data1),
        .en_out0         (en_out0),
        .en_out1         (en_out1),
        .addr_out0       (addr_out0),
        .addr_out1       (addr_out1),
        .data_out0       (data_out0),
        .data_out1       (data_out1),
        .pc_out0         (pc_out0),
        .pc_out1         (pc_out1),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .branch_pc       (branch_pc)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_stage;

    typedef struct {
        logic               en0, br0, sel0, en1, sel1, wbf;
        exe_pkg::alu_op_t   op0, op1;
        exe_pkg::br_op_t    bop0;
        exe_pkg::reg_addr_t rd0, rj0, rk0, rd1, rj1, rk1;
        exe_pkg::word_t     imm0, pc0, pcn0, rf00, rf01, imm1, pc1, rf10, rf11;
        logic               x_en0, x_en1, x_flush;
        exe_pkg::word_t     x_data0, x_data1, x_redirect, x_bpc;
    } row_t;

    logic clk, rst_n, wb_flush;
    logic lane0_en, lane0_is_branch, lane0_src2_imm, lane1_en, lane1_src2_imm;
    exe_pkg::alu_op_t   lane0_alu_op, lane1_alu_op;
    exe_pkg::br_op_t    lane0_br_op;
    exe_pkg::reg_addr_t lane0_rd, lane0_rj, lane0_rk, lane1_rd, lane1_rj, lane1_rk;
    exe_pkg::word_t     lane0_imm, lane0_pc, lane0_pc_next, rf_data00, rf_data01;
    exe_pkg::word_t     lane1_imm, lane1_pc, rf_data10, rf_data11;
    logic               en_out0, en_out1, flush;
    exe_pkg::reg_addr_t addr_out0, addr_out1;
    exe_pkg::word_t     data_out0, data_out1, pc_out0, pc_out1, redirect_pc, branch_pc;

    row_t tbl[$];
    int   n_rows = 0;

    exe_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reference ALU rule
    function automatic exe_pkg::word_t alu_ref(input exe_pkg::alu_op_t op,
                                               input exe_pkg::word_t a, input exe_pkg::word_t b);
        case (op)
            exe_pkg::alu_add:  return a + b;
            exe_pkg::alu_sub:  return a - b;
            exe_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_and:  return a & b;
            exe_pkg::alu_or:   return a | b;
            exe_pkg::alu_xor:  return a ^ b;
            exe_pkg::alu_nor:  return ~(a | b);
            exe_pkg::alu_sll:  return a << b[4:0];
            exe_pkg::alu_srl:  return a >> b[4:0];
            exe_pkg::alu_sra:  return $signed(a) >>> b[4:0];
            exe_pkg::alu_lui:  return b;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r = '{default: '0, op0: exe_pkg::alu_add, op1: exe_pkg::alu_add, bop0: exe_pkg::br_b};
        return r;
    endfunction

    // lane 0 reads r1/r2, lane 1 reads r3/r4
    function automatic row_t alu_row(
        input exe_pkg::alu_op_t op0, input logic sel0, input exe_pkg::reg_addr_t rd0,
        input exe_pkg::word_t a0, input exe_pkg::word_t b0,
        input exe_pkg::alu_op_t op1, input logic sel1, input exe_pkg::reg_addr_t rd1,
        input exe_pkg::word_t a1, input exe_pkg::word_t b1, input exe_pkg::word_t pc);
        row_t r;
        r = blank_row();
        r.en0 = 1'b1;
        r.op0 = op0;
        r.sel0 = sel0;
        r.rd0 = rd0;
        r.rj0 = 5'd1;
        r.rk0 = 5'd2;
        r.rf00 = a0;
        r.rf01 = sel0 ? ~b0 : b0;
        r.imm0 = sel0 ? b0 : ~b0;
        r.en1 = 1'b1;
        r.op1 = op1;
        r.sel1 = sel1;
        r.rd1 = rd1;
        r.rj1 = 5'd3;
        r.rk1 = 5'd4;
        r.rf10 = a1;
        r.rf11 = sel1 ? ~b1 : b1;
        r.imm1 = sel1 ? b1 : ~b1;
        r.pc0 = pc;
        r.pc1 = pc + 32'd4;
        r.x_en0 = rd0 != 5'd0;
        r.x_en1 = rd1 != 5'd0;
        r.x_data0 = alu_ref(op0, a0, b0);
        r.x_data1 = alu_ref(op1, a1, b1);
        return r;
    endfunction

    function automatic row_t branch_row(input exe_pkg::br_op_t bop, input exe_pkg::reg_addr_t rd,
                                        input exe_pkg::word_t a, input exe_pkg::word_t b,
                                        input exe_pkg::word_t imm, input exe_pkg::word_t pc,
                                        input exe_pkg::word_t pcn, input exe_pkg::reg_addr_t rd1);
        row_t r;
        r = alu_row(exe_pkg::alu_add, 1'b0, rd, a, b,
                    exe_pkg::alu_lui, 1'b1, rd1, 32'd0, 32'h77, pc);
        r.br0 = 1'b1;
        r.bop0 = bop;
        r.imm0 = imm;
        r.pcn0 = pcn;
        r.x_en0 = (bop == exe_pkg::br_bl || bop == exe_pkg::br_jirl) && rd != 5'd0;
        r.x_data0 = pc + 32'd4;
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        exe_pkg::alu_op_t op;
        repeat (3) tbl.push_back(blank_row());
        for (int k = 0; k < 24; k++) begin
            op = exe_pkg::alu_op_t'(4'(k % 12));
            tbl.push_back(alu_row(op, k >= 12, exe_pkg::reg_addr_t'(5'd10 + 5'(k % 12)),
                                  $urandom, $urandom,
                                  op, k < 12, exe_pkg::reg_addr_t'(5'd20 + 5'(k % 12)),
                                  $urandom, $urandom, 32'h1000 + 32'(k * 8)));
        end
        // destination r0 never enables
        tbl.push_back(alu_row(exe_pkg::alu_add, 1'b0, 5'd0, 32'd5, 32'd6,
                              exe_pkg::alu_lui, 1'b1, 5'd0, 32'd1, 32'd2, 32'h1100));
        tbl.push_back(blank_row());
        tbl.push_back(alu_row(exe_pkg::alu_lui, 1'b1, 5'd6, 32'h0bad, 32'd111,
                              exe_pkg::alu_lui, 1'b1, 5'd6, 32'h0bad, 32'd222, 32'h1200));
        r = alu_row(exe_pkg::alu_add, 1'b0, 5'd7, 32'h0bad, 32'd99,
                    exe_pkg::alu_lui, 1'b1, 5'd8, 32'h0bad, 32'd333, 32'h1208);
        r.rj0 = 5'd6;
        r.rk0 = 5'd0;
        r.x_data0 = 32'd222;
        tbl.push_back(r);
        r = alu_row(exe_pkg::alu_add, 1'b0, 5'd9, 32'h0bad, 32'h0bad,
                    exe_pkg::alu_add, 1'b0, 5'd10, 32'h0bad, 32'h0bad, 32'h1210);
        r.rj0 = 5'd7;
        r.rk0 = 5'd6;
        r.rj1 = 5'd8;
        r.rk1 = 5'd6;
        r.x_data0 = 32'd444;
        r.x_data1 = 32'd555;
        tbl.push_back(r);
        repeat (2) tbl.push_back(blank_row());
        // link registers kept clear of the r1..r4 sources read by later rows
        tbl.push_back(branch_row(exe_pkg::br_bl, 5'd22, 32'd0, 32'd0, 32'h40, 32'h100,
                                 32'h140, 5'd12));
        tbl.push_back(branch_row(exe_pkg::br_jirl, 5'd23, 32'h2000, 32'd0, 32'h10, 32'h200,
                                 32'h2010, 5'd0));
        tbl.push_back(branch_row(exe_pkg::br_beq, 5'd5, 32'd5, 32'd6, 32'h80, 32'h300,
                                 32'h304, 5'd0));
        r = branch_row(exe_pkg::br_blt, 5'd0, -32'sd5, 32'd3, 32'h20, 32'h400, 32'h404, 5'd13);
        r.x_en1 = 1'b0;
        r.x_flush = 1'b1;
        r.x_redirect = 32'h420;
        r.x_bpc = 32'h400;
        tbl.push_back(r);
        r = alu_row(exe_pkg::alu_lui, 1'b1, 5'd14, 32'd0, 32'd1,
                    exe_pkg::alu_lui, 1'b1, 5'd15, 32'd0, 32'd2, 32'h408);
        r.x_en0 = 1'b0;
        r.x_en1 = 1'b0;
        tbl.push_back(r);
        tbl.push_back(alu_row(exe_pkg::alu_lui, 1'b1, 5'd16, 32'd0, 32'd3,
                              exe_pkg::alu_lui, 1'b1, 5'd17, 32'd0, 32'd4, 32'h420));
        // wb_flush comes with the second bundle, first one sits in the middle stage
        for (int k = 0; k < 2; k++) begin
            r = alu_row(exe_pkg::alu_lui, 1'b1, 5'd18, 32'd0, 32'd5,
                        exe_pkg::alu_lui, 1'b1, 5'd19, 32'd0, 32'd6, 32'h500);
            r.x_en0 = 1'b0;
            r.x_en1 = 1'b0;
            r.wbf = k == 1;
            tbl.push_back(r);
        end
        tbl.push_back(alu_row(exe_pkg::alu_sub, 1'b1, 5'd20, 32'd9, 32'd4,
                              exe_pkg::alu_or, 1'b0, 5'd21, 32'h0f, 32'hf0, 32'h600));
        repeat (3) tbl.push_back(blank_row());
        n_rows = tbl.size();
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic drive(input row_t r);
        wb_flush = r.wbf;
        lane0_en = r.en0;
        lane0_is_branch = r.br0;
        lane0_alu_op = r.op0;
        lane0_br_op = r.bop0;
        lane0_src2_imm = r.sel0;
        lane0_rd = r.rd0;
        lane0_rj = r.rj0;
        lane0_rk = r.rk0;
        lane0_imm = r.imm0;
        lane0_pc = r.pc0;
        lane0_pc_next = r.pcn0;
        rf_data00 = r.rf00;
        rf_data01 = r.rf01;
        lane1_en = r.en1;
        lane1_alu_op = r.op1;
        lane1_src2_imm = r.sel1;
        lane1_rd = r.rd1;
        lane1_rj = r.rj1;
        lane1_rk = r.rk1;
        lane1_imm = r.imm1;
        lane1_pc = r.pc1;
        rf_data10 = r.rf10;
        rf_data11 = r.rf11;
    endtask

    task automatic check_outputs(input row_t r, input int idx);
        check($sformatf("row %0d en_out0", idx), {31'd0, en_out0}, {31'd0, r.x_en0});
        check($sformatf("row %0d en_out1", idx), {31'd0, en_out1}, {31'd0, r.x_en1});
        if (r.x_en0) begin
            check($sformatf("row %0d addr_out0", idx), {27'd0, addr_out0}, {27'd0, r.rd0});
            check($sformatf("row %0d data_out0", idx), data_out0, r.x_data0);
            check($sformatf("row %0d pc_out0", idx), pc_out0, r.pc0);
        end
        if (r.x_en1) begin
            check($sformatf("row %0d addr_out1", idx), {27'd0, addr_out1}, {27'd0, r.rd1});
            check($sformatf("row %0d data_out1", idx), data_out1, r.x_data1);
            check($sformatf("row %0d pc_out1", idx), pc_out1, r.pc1);
        end
    endtask

    task automatic check_flush(input row_t r, input int idx);
        check($sformatf("row %0d flush", idx), {31'd0, flush}, {31'd0, r.x_flush});
        if (r.x_flush) begin
            check($sformatf("row %0d redirect_pc", idx), redirect_pc, r.x_redirect);
            check($sformatf("row %0d branch_pc", idx), branch_pc, r.x_bpc);
        end
    endtask

    initial begin
        void'($urandom(32'haaaeefdc));
        rst_n = 1'b0;
        drive(blank_row());
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // row i reaches the outputs two falling edges later, flush one edge later
        for (int i = 0; i < n_rows + 2; i++) begin
            @(negedge clk);
            if (i >= 2)
                check_outputs(tbl[i-2], i - 2);
            if (i >= 1)
                check_flush(tbl[i-1], i - 1);
            if (i < n_rows)
                drive(tbl[i]);
            else
                drive(blank_row());
        end
        $display("all tests passed");
        $finish;
    end

    initial begin
        wait (n_rows > 0);
        repeat (n_rows + 10) @(posedge clk);
        $display("timeout: the table did not finish in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/exe_pkg.sv
hdl/exe_forward.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_pipe.sv
hdl/exe_stage.sv
testbench/tb_exe_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_exe_stage -o sim_exe_stage

# the simulator may exit nonzero on failure, the log decides
./obj_dir/sim_exe_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi
